// File: flist.f
+incdir+hdl
+incdir+tb
hdl/ctrl_pkg.sv
hdl/ctrl_fsm.sv
hdl/trap_ctrl.sv
hdl/core_controller.sv
tb/tb_core_controller.sv

// File: Makefile
# Verilator build and run of the core controller testbench

VERILATOR ?= verilator
TOP       ?= tb_core_controller
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard hdl/*.svh tb/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_tasks.svh
/*
  directed tests of the core controller, included inside the testbench top
  each test starts and ends on a falling edge, with fetch enabled and in DECODE
  interrupt ids come from the seeded random generator of the top
*/

//////////////////////////////
// check helpers
//////////////////////////////
task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
  check_cnt++;
  assert (got === exp) else begin
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    err_cnt++;
  end
endtask

// plain worded failure such as a timeout
task automatic confirm(input logic cond, input string what);
  check_cnt++;
  assert (cond === 1'b1) else begin
    $display("%s at %0t", what, $time);
    err_cnt++;
  end
endtask

task automatic report_test(input string name, input int err_start);
  test_cnt++;
  if (err_cnt == err_start) begin
    $display("test %s: ok", name);
  end else begin
    test_fail_cnt++;
    $display("test %s: %0d errors", name, err_cnt - err_start);
  end
endtask

//////////////////////////////
// reset, boot and first fetch
//////////////////////////////
task automatic boot_after_reset();
  int err_start;
  int n;
  err_start = err_cnt;
  compare_value("ctrl_busy_o", 32'(ctrl_busy_o), 0);
  compare_value("instr_req_o", 32'(instr_req_o), 0);
  compare_value("pc_set_o", 32'(pc_set_o), 0);
  compare_value("state", 32'(dut0.u_fsm.state_q), 32'(RESET));
  @(posedge clk);
  fetch_enable_i <= 1'b1;
  @(negedge clk);
  // boot pc comes one cycle after fetch enable is seen
  n = 0;
  while (pc_set_o !== 1'b1 && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  confirm(pc_set_o, "timeout waiting for the boot pc_set_o");
  compare_value("boot delay", n, 1);
  compare_value("pc_mux_o", 32'(pc_mux_o), 32'(`CTRL_PC_BOOT));
  // FSM holds in first fetch while id_ready_i is low
  repeat (3) begin
    @(negedge clk);
    compare_value("state", 32'(dut0.u_fsm.state_q), 32'(FIRST_FETCH));
    compare_value("first_fetch_o", 32'(first_fetch_o), 1);
    compare_value("instr_req_o", 32'(instr_req_o), 1);
  end
  @(posedge clk);
  id_ready_i <= 1'b1;
  @(negedge clk);
  n = 0;
  while (dut0.u_fsm.state_q != DECODE && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  confirm(dut0.u_fsm.state_q == DECODE, "timeout waiting for decode after id_ready_i");
  report_test("boot_after_reset", err_start);
endtask

//////////////////////////////
// jump and taken branch
//////////////////////////////
task automatic redirect_on_jump();
  int err_start;
  err_start = err_cnt;
  @(posedge clk);
  instr_valid_i <= 1'b1;
  jump_set_i    <= 1'b1;
  @(negedge clk);
  compare_value("pc_set_o", 32'(pc_set_o), 1);
  compare_value("pc_mux_o", 32'(pc_mux_o), 32'(`CTRL_PC_JUMP));
  compare_value("halt_if_o", 32'(halt_if_o), 0);
  compare_value("deassert_we_o", 32'(deassert_we_o), 0);
  @(posedge clk);
  jump_set_i   <= 1'b0;
  branch_set_i <= 1'b1;
  @(negedge clk);
  compare_value("pc_set_o", 32'(pc_set_o), 1);
  compare_value("pc_mux_o", 32'(pc_mux_o), 32'(`CTRL_PC_JUMP));
  compare_value("halt_if_o", 32'(halt_if_o), 0);
  @(posedge clk);
  branch_set_i  <= 1'b0;
  instr_valid_i <= 1'b0;
  @(negedge clk);
  compare_value("pc_set_o", 32'(pc_set_o), 0);
  compare_value("state", 32'(dut0.u_fsm.state_q), 32'(DECODE));
  report_test("redirect_on_jump", err_start);
endtask

//////////////////////////////
// ecall and illegal instruction
//////////////////////////////
task automatic trap_on_exception();
  int                         err_start;
  int                         n;
  int                         k;
  int                         exp_cause;
  logic [`CTRL_EXC_MUX_W-1:0] exp_vec;
  err_start = err_cnt;
  for (k = 0; k < 2; k++) begin
    // ecall in the first pass and illegal in the second
    exp_cause = (k == 0) ? 11 : 2;
    exp_vec   = (k == 0) ? `CTRL_EXC_PC_ECALL : `CTRL_EXC_PC_ILLINSN;
    @(posedge clk);
    instr_valid_i  <= 1'b1;
    ecall_insn_i   <= (k == 0);
    illegal_insn_i <= (k == 1);
    @(negedge clk);
    compare_value("halt_id_o", 32'(halt_id_o), 1);
    compare_value("halt_if_o", 32'(halt_if_o), 1);
    compare_value("pc_set_o", 32'(pc_set_o), 0);
    if (k == 1) begin
      compare_value("deassert_we_o", 32'(deassert_we_o), 1);
    end
    n = 0;
    while (pc_set_o !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    confirm(pc_set_o, "timeout waiting for the exception pc_set_o");
    compare_value("pc_mux_o", 32'(pc_mux_o), 32'(`CTRL_PC_EXCEPTION));
    compare_value("exc_pc_mux_o", 32'(exc_pc_mux_o), 32'(exp_vec));
    compare_value("exc_cause_o", 32'(exc_cause_o), exp_cause);
    compare_value("csr_cause_o", 32'(csr_cause_o), exp_cause);
    compare_value("csr_save_id_o", 32'(csr_save_id_o), 1);
    if (k == 1) begin
      compare_value("deassert_we_o", 32'(deassert_we_o), 1);
    end
    // flags drop as ID moves on
    @(posedge clk);
    instr_valid_i  <= 1'b0;
    ecall_insn_i   <= 1'b0;
    illegal_insn_i <= 1'b0;
    @(negedge clk);
    compare_value("pc_set_o", 32'(pc_set_o), 0);
    compare_value("state", 32'(dut0.u_fsm.state_q), 32'(DECODE));
  end
  report_test("trap_on_exception", err_start);
endtask

//////////////////////////////
// mret into sleep, wake on irq
//////////////////////////////
task automatic sleep_after_mret();
  int err_start;
  int n;
  err_start = err_cnt;
  @(posedge clk);
  fetch_enable_i <= 1'b0;
  instr_valid_i  <= 1'b1;
  mret_insn_i    <= 1'b1;
  @(negedge clk);
  compare_value("halt_id_o", 32'(halt_id_o), 1);
  n = 0;
  while (pc_set_o !== 1'b1 && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  confirm(pc_set_o, "timeout waiting for the mret pc_set_o");
  compare_value("pc_mux_o", 32'(pc_mux_o), 32'(`CTRL_PC_ERET));
  compare_value("csr_restore_mret_id_o", 32'(csr_restore_mret_id_o), 1);
  @(posedge clk);
  mret_insn_i   <= 1'b0;
  instr_valid_i <= 1'b0;
  @(negedge clk);
  n = 0;
  while (ctrl_busy_o !== 1'b0 && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  confirm(!ctrl_busy_o, "ctrl_busy_o did not fall after mret");
  n = 0;
  while (dut0.u_fsm.state_q != SLEEP && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  confirm(dut0.u_fsm.state_q == SLEEP, "controller never reached sleep");
  compare_value("instr_req_o", 32'(instr_req_o), 0);
  // wake request while interrupts stay masked
  @(posedge clk);
  irq_req_i <= 1'b1;
  @(negedge clk);
  n = 0;
  while (ctrl_busy_o !== 1'b1 && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  confirm(ctrl_busy_o, "ctrl_busy_o did not rise on the wake request");
  @(posedge clk);
  irq_req_i      <= 1'b0;
  fetch_enable_i <= 1'b1;
  @(negedge clk);
  n = 0;
  while (dut0.u_fsm.state_q != DECODE && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  confirm(dut0.u_fsm.state_q == DECODE, "timeout waiting for decode after wake up");
  report_test("sleep_after_mret", err_start);
endtask

//////////////////////////////
// enabled and masked interrupts
//////////////////////////////
task automatic take_interrupts();
  int                        err_start;
  int                        n;
  logic                      acked;
  logic [`CTRL_IRQ_ID_W-1:0] id;
  err_start = err_cnt;
  id = 5'($random(seed));
  @(posedge clk);
  m_ie_i    <= 1'b1;
  irq_req_i <= 1'b1;
  irq_id_i  <= id;
  @(negedge clk);
  n = 0;
  while (irq_ack_o !== 1'b1 && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  confirm(irq_ack_o, "timeout waiting for irq_ack_o");
  compare_value("exc_ack_o", 32'(exc_ack_o), 1);
  compare_value("pc_set_o", 32'(pc_set_o), 1);
  compare_value("pc_mux_o", 32'(pc_mux_o), 32'(`CTRL_PC_EXCEPTION));
  compare_value("exc_pc_mux_o", 32'(exc_pc_mux_o), 32'(`CTRL_EXC_PC_IRQ));
  // interrupt flag on top of the id in mcause only
  compare_value("csr_cause_o", 32'(csr_cause_o), 32'({1'b1, id}));
  compare_value("exc_cause_o", 32'(exc_cause_o), 32'({1'b0, id}));
  compare_value("irq_id_o", 32'(irq_id_o), 32'(id));
  compare_value("csr_save_cause_o", 32'(csr_save_cause_o), 1);
  // return point is the next fetch address
  compare_value("csr_save_if_o", 32'(csr_save_if_o), 1);
  // request is withdrawn on the ack
  @(posedge clk);
  irq_req_i <= 1'b0;
  @(negedge clk);
  compare_value("irq_ack_o", 32'(irq_ack_o), 0);
  compare_value("exc_ack_o", 32'(exc_ack_o), 0);
  // masked request must never be taken
  id = 5'($random(seed));
  @(posedge clk);
  m_ie_i    <= 1'b0;
  irq_req_i <= 1'b1;
  irq_id_i  <= id;
  @(negedge clk);
  acked = 1'b0;
  n = 0;
  while (n < TIMEOUT) begin
    if (irq_ack_o === 1'b1 || exc_ack_o === 1'b1) begin
      acked = 1'b1;
    end
    @(negedge clk);
    n++;
  end
  confirm(!acked, "masked interrupt was acknowledged");
  compare_value("exc_kill_o", 32'(exc_kill_o), 1);
  @(posedge clk);
  irq_req_i <= 1'b0;
  @(negedge clk);
  compare_value("exc_kill_o", 32'(exc_kill_o), 0);
  report_test("take_interrupts", err_start);
endtask

// File: tb/tb_core_controller.sv
/*
  testbench for the core controller top level
  inputs change on the rising edge, outputs are sampled on the falling edge
  the FSM state is read through the hierarchy for the sleep and boot checks
  every wait is bounded, a timeout counts as an error and the run goes on
*/
`timescale 1ns/1ps
`include "ctrl_params.svh"

module tb_core_controller import ctrl_pkg::*; ();

  // cycles allowed for any single wait
  localparam int TIMEOUT = 20;

  logic clk = 1'b0;
  logic rst_n;

  // DUT inputs
  logic                       fetch_enable_i;
  logic                       instr_valid_i;
  logic                       id_ready_i;
  logic                       instr_multicycle_i;
  logic                       branch_in_id_i;
  logic                       branch_set_i;
  logic                       jump_set_i;
  logic                       ecall_insn_i;
  logic                       illegal_insn_i;
  logic                       mret_insn_i;
  logic                       ebrk_insn_i;
  logic                       pipe_flush_i;
  logic                       csr_status_i;
  logic                       irq_req_i;
  logic [`CTRL_IRQ_ID_W-1:0]  irq_id_i;
  logic                       m_ie_i;

  // DUT outputs
  logic                       halt_if_o;
  logic                       halt_id_o;
  logic                       ctrl_busy_o;
  logic                       instr_req_o;
  logic                       first_fetch_o;
  logic                       exc_kill_o;
  logic                       deassert_we_o;
  logic                       pc_set_o;
  logic [`CTRL_PC_MUX_W-1:0]  pc_mux_o;
  logic [`CTRL_EXC_MUX_W-1:0] exc_pc_mux_o;
  logic [`CTRL_CAUSE_W-1:0]   exc_cause_o;
  logic [`CTRL_CAUSE_W-1:0]   csr_cause_o;
  logic                       csr_save_if_o;
  logic                       csr_save_id_o;
  logic                       csr_save_cause_o;
  logic                       csr_restore_mret_id_o;
  logic                       irq_ack_o;
  logic                       exc_ack_o;
  logic [`CTRL_IRQ_ID_W-1:0]  irq_id_o;

  // bookkeeping
  int     err_cnt = 0;
  int     check_cnt = 0;
  int     test_cnt = 0;
  int     test_fail_cnt = 0;
  integer seed;

  always #20 clk = ~clk;

  core_controller dut0 (.*);

  `include "tb_tasks.svh"

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    seed               = 84020;
    rst_n              = 1'b0;
    fetch_enable_i     = 1'b0;
    instr_valid_i      = 1'b0;
    id_ready_i         = 1'b0;
    instr_multicycle_i = 1'b0;
    branch_in_id_i     = 1'b0;
    branch_set_i       = 1'b0;
    jump_set_i         = 1'b0;
    ecall_insn_i       = 1'b0;
    illegal_insn_i     = 1'b0;
    mret_insn_i        = 1'b0;
    ebrk_insn_i        = 1'b0;
    pipe_flush_i       = 1'b0;
    csr_status_i       = 1'b0;
    irq_req_i          = 1'b0;
    irq_id_i           = '0;
    m_ie_i             = 1'b0;

    // reset held for 8 cycles
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    boot_after_reset();
    redirect_on_jump();
    trap_on_exception();
    sleep_after_mret();
    take_interrupts();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, test_fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/core_controller.sv
/*
  top of the core controller, FSM plus trap block
  single-cycle strobes throughout, no back-pressure besides id_ready_i
  interrupt enable comes from the CSR file
*/
`timescale 1ns/1ps
`include "ctrl_params.svh"

module core_controller import ctrl_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,

  // fetch and ID stage
  input  logic                        fetch_enable_i,
  input  logic                        instr_valid_i,
  input  logic                        id_ready_i,
  input  logic                        instr_multicycle_i,
  input  logic                        branch_in_id_i,
  input  logic                        branch_set_i,
  input  logic                        jump_set_i,

  // decoder flags
  input  logic                        ecall_insn_i,
  input  logic                        illegal_insn_i,
  input  logic                        mret_insn_i,
  input  logic                        ebrk_insn_i,
  input  logic                        pipe_flush_i,
  input  logic                        csr_status_i,

  // interrupts
  input  logic                        irq_req_i,
  input  logic [`CTRL_IRQ_ID_W-1:0]   irq_id_i,
  input  logic                        m_ie_i,

  output logic                        halt_if_o,
  output logic                        halt_id_o,
  output logic                        ctrl_busy_o,
  output logic                        instr_req_o,
  output logic                        first_fetch_o,
  output logic                        exc_kill_o,
  output logic                        deassert_we_o,

  // fetch redirect
  output logic                        pc_set_o,
  output logic [`CTRL_PC_MUX_W-1:0]   pc_mux_o,
  output logic [`CTRL_EXC_MUX_W-1:0]  exc_pc_mux_o,

  // CSR file and interrupt controller
  output logic [`CTRL_CAUSE_W-1:0]    exc_cause_o,
  output logic [`CTRL_CAUSE_W-1:0]    csr_cause_o,
  output logic                        csr_save_if_o,
  output logic                        csr_save_id_o,
  output logic                        csr_save_cause_o,
  output logic                        csr_restore_mret_id_o,
  output logic                        irq_ack_o,
  output logic                        exc_ack_o,
  output logic [`CTRL_IRQ_ID_W-1:0]   irq_id_o
);

  // FSM to trap block
  pc_event_e pc_event;
  logic      decoding;
  // trap block to FSM
  logic      flush_req;
  logic      sleep_after_flush;

  ctrl_fsm u_fsm (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_enable_i      (fetch_enable_i),
    .instr_valid_i       (instr_valid_i),
    .id_ready_i          (id_ready_i),
    .irq_req_i           (irq_req_i),
    .m_ie_i              (m_ie_i),
    .instr_multicycle_i  (instr_multicycle_i),
    .branch_in_id_i      (branch_in_id_i),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .flush_req_i         (flush_req),
    .sleep_after_flush_i (sleep_after_flush),
    .pc_event_o          (pc_event),
    .decoding_o          (decoding),
    .halt_if_o           (halt_if_o),
    .halt_id_o           (halt_id_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .instr_req_o         (instr_req_o),
    .first_fetch_o       (first_fetch_o),
    .exc_kill_o          (exc_kill_o)
  );

  trap_ctrl u_trap (
    .pc_event_i            (pc_event),
    .decoding_i            (decoding),
    .ecall_insn_i          (ecall_insn_i),
    .illegal_insn_i        (illegal_insn_i),
    .mret_insn_i           (mret_insn_i),
    .ebrk_insn_i           (ebrk_insn_i),
    .pipe_flush_i          (pipe_flush_i),
    .csr_status_i          (csr_status_i),
    .irq_id_i              (irq_id_i),
    .flush_req_o           (flush_req),
    .sleep_after_flush_o   (sleep_after_flush),
    .pc_set_o              (pc_set_o),
    .pc_mux_o              (pc_mux_o),
    .exc_pc_mux_o          (exc_pc_mux_o),
    .exc_cause_o           (exc_cause_o),
    .csr_cause_o           (csr_cause_o),
    .csr_save_if_o         (csr_save_if_o),
    .csr_save_id_o         (csr_save_id_o),
    .csr_save_cause_o      (csr_save_cause_o),
    .csr_restore_mret_id_o (csr_restore_mret_id_o),
    .irq_ack_o             (irq_ack_o),
    .exc_ack_o             (exc_ack_o),
    .irq_id_o              (irq_id_o),
    .deassert_we_o         (deassert_we_o)
  );

endmodule

// File: hdl/trap_ctrl.sv
/*
  trap and pc selection block, purely combinational
  acts on the pc event of the current cycle, no handshake
  on flush the cause priority is ecall, illegal, mret, ebreak
  csr status and pipe flush only drain the pipe
*/
`timescale 1ns/1ps
`include "ctrl_params.svh"

module trap_ctrl import ctrl_pkg::*; (
  input  pc_event_e                   pc_event_i,
  input  logic                        decoding_i,
  input  logic                        ecall_insn_i,
  input  logic                        illegal_insn_i,
  input  logic                        mret_insn_i,
  input  logic                        ebrk_insn_i,
  input  logic                        pipe_flush_i,
  input  logic                        csr_status_i,
  input  logic [`CTRL_IRQ_ID_W-1:0]   irq_id_i,

  output logic                        flush_req_o,
  output logic                        sleep_after_flush_o,
  output logic                        pc_set_o,
  output logic [`CTRL_PC_MUX_W-1:0]   pc_mux_o,
  output logic [`CTRL_EXC_MUX_W-1:0]  exc_pc_mux_o,
  output logic [`CTRL_CAUSE_W-1:0]    exc_cause_o,
  output logic [`CTRL_CAUSE_W-1:0]    csr_cause_o,
  output logic                        csr_save_if_o,
  output logic                        csr_save_id_o,
  output logic                        csr_save_cause_o,
  output logic                        csr_restore_mret_id_o,
  output logic                        irq_ack_o,
  output logic                        exc_ack_o,
  output logic [`CTRL_IRQ_ID_W-1:0]   irq_id_o,
  output logic                        deassert_we_o
);

  trap_cause_u exc_cause;
  trap_cause_u csr_cause;

  // decoder requests towards the FSM
  assign flush_req_o = ecall_insn_i | illegal_insn_i | mret_insn_i |
                       ebrk_insn_i | pipe_flush_i | csr_status_i;
  // only these two may end in sleep
  assign sleep_after_flush_o = mret_insn_i | pipe_flush_i;

  assign irq_id_o    = irq_id_i;
  assign exc_cause_o = exc_cause.raw;
  assign csr_cause_o = csr_cause.raw;

  // no register write outside decode or for an illegal encoding
  assign deassert_we_o = ~decoding_i | illegal_insn_i;

  //////////////////////////////
  // pc event decoding
  //////////////////////////////
  always_comb begin
    pc_set_o              = 1'b0;
    pc_mux_o              = `CTRL_PC_BOOT;
    exc_pc_mux_o          = `CTRL_EXC_PC_IRQ;
    exc_cause.raw         = '0;
    csr_cause.raw         = '0;
    csr_save_if_o         = 1'b0;
    csr_save_id_o         = 1'b0;
    csr_save_cause_o      = 1'b0;
    csr_restore_mret_id_o = 1'b0;
    irq_ack_o             = 1'b0;
    exc_ack_o             = 1'b0;

    unique case (pc_event_i)
      EV_BOOT: begin
        pc_set_o = 1'b1;
        pc_mux_o = `CTRL_PC_BOOT;
      end

      EV_JUMP: begin
        pc_set_o = 1'b1;
        pc_mux_o = `CTRL_PC_JUMP;
      end

      EV_IRQ: begin
        pc_set_o           = 1'b1;
        pc_mux_o           = `CTRL_PC_EXCEPTION;
        exc_pc_mux_o       = `CTRL_EXC_PC_IRQ;
        // vector offset uses the bare id, mcause gets the flag
        exc_cause.f.irq    = 1'b0;
        exc_cause.f.code   = irq_id_i;
        csr_cause.f.irq    = 1'b1;
        csr_cause.f.code   = irq_id_i;
        csr_save_cause_o   = 1'b1;
        // next fetch address is the return point
        csr_save_if_o      = 1'b1;
        irq_ack_o          = 1'b1;
        exc_ack_o          = 1'b1;
      end

      EV_FLUSH: begin
        if (ecall_insn_i) begin
          pc_set_o         = 1'b1;
          pc_mux_o         = `CTRL_PC_EXCEPTION;
          exc_pc_mux_o     = `CTRL_EXC_PC_ECALL;
          exc_cause.raw    = `CTRL_CAUSE_ECALL_M;
          csr_cause.raw    = `CTRL_CAUSE_ECALL_M;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
        end else if (illegal_insn_i) begin
          pc_set_o         = 1'b1;
          pc_mux_o         = `CTRL_PC_EXCEPTION;
          exc_pc_mux_o     = `CTRL_EXC_PC_ILLINSN;
          exc_cause.raw    = `CTRL_CAUSE_ILLEGAL;
          csr_cause.raw    = `CTRL_CAUSE_ILLEGAL;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
        end else if (mret_insn_i) begin
          // return to mepc and restore the status bits
          pc_set_o              = 1'b1;
          pc_mux_o              = `CTRL_PC_ERET;
          csr_restore_mret_id_o = 1'b1;
        end else if (ebrk_insn_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = `CTRL_PC_DBG_DPC;
          exc_cause.raw = `CTRL_CAUSE_BREAKPOINT;
        end
        // csr status and pipe flush need no redirect
      end

      default: begin
        // EV_NONE, nothing this cycle
      end
    endcase
  end

endmodule

// File: hdl/ctrl_fsm.sv
/*
  main controller FSM, state register and next-state logic
  decode priority is branch, jump, flush, then interrupt
  decoder flags must stay held while ID is halted in FLUSH
  FIRST_FETCH waits on id_ready_i without any bound
*/
`timescale 1ns/1ps

module ctrl_fsm import ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  input  logic      fetch_enable_i,
  input  logic      instr_valid_i,
  input  logic      id_ready_i,
  input  logic      irq_req_i,
  input  logic      m_ie_i,
  input  logic      instr_multicycle_i,
  input  logic      branch_in_id_i,
  input  logic      branch_set_i,
  input  logic      jump_set_i,
  input  logic      flush_req_i,
  input  logic      sleep_after_flush_i,

  output pc_event_e pc_event_o,
  output logic      decoding_o,
  output logic      halt_if_o,
  output logic      halt_id_o,
  output logic      ctrl_busy_o,
  output logic      instr_req_o,
  output logic      first_fetch_o,
  output logic      exc_kill_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // interrupt may be taken in decode when the ID stage allows it
  logic irq_pending;
  logic interruptible;

  assign irq_pending   = irq_req_i & m_ie_i;
  // nothing in ID, or a plain single-cycle instruction outside a branch
  assign interruptible = ~instr_valid_i | (~instr_multicycle_i & ~branch_in_id_i);

  //////////////////////////////
  // next state and outputs
  //////////////////////////////
  always_comb begin
    // defaults, core running and fetching
    state_d       = state_q;
    pc_event_o    = EV_NONE;
    decoding_o    = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    ctrl_busy_o   = 1'b1;
    instr_req_o   = 1'b1;
    first_fetch_o = 1'b0;
    exc_kill_o    = 1'b0;

    unique case (state_q)
      // idle after reset until fetch enable
      RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load the boot address into the fetch stage
      BOOT_SET: begin
        pc_event_o = EV_BOOT;
        state_d    = FIRST_FETCH;
      end

      // one cycle to let the flush settle before sleeping
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = SLEEP;
      end

      // wake on fetch enable or any interrupt request, enabled or not
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || irq_req_i) begin
          state_d = FIRST_FETCH;
        end
      end

      FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        // stall until the first instruction reaches ID
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // pipeline is empty here, so an interrupt can go straight in
        if (irq_pending) begin
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      DECODE: begin
        if (instr_valid_i) begin
          decoding_o = 1'b1;
          if (branch_set_i || jump_set_i) begin
            // taken branch or jump, redirect fetch in this cycle
            pc_event_o = EV_JUMP;
          end else if (flush_req_i) begin
            // trap or system instruction, drain first
            state_d   = FLUSH;
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
          end else if (irq_pending && interruptible) begin
            state_d   = IRQ_TAKEN;
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
          end else begin
            // masked request on an instruction that could be interrupted
            exc_kill_o = irq_req_i & ~m_ie_i & interruptible;
          end
        end else begin
          // bubble in ID
          if (irq_pending) begin
            state_d   = IRQ_TAKEN;
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
          end else begin
            exc_kill_o = irq_req_i;
          end
        end
      end

      // single cycle, trap block does the vector and CSR work
      IRQ_TAKEN: begin
        pc_event_o = EV_IRQ;
        state_d    = DECODE;
      end

      // pipe drained, trap block picks the cause
      FLUSH: begin
        pc_event_o = EV_FLUSH;
        halt_if_o  = ~fetch_enable_i;
        halt_id_o  = 1'b1;
        if (!fetch_enable_i && sleep_after_flush_i) begin
          state_d = WAIT_SLEEP;
        end else begin
          state_d = DECODE;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////
  // state register
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: hdl/ctrl_pkg.sv
/*
  types shared by the controller FSM, the trap block and the testbench
  the state encoding is fixed at 4 bits, the pc event at 3 bits
  the cause union overlays a raw cause word on its flag and code fields
*/
`include "ctrl_params.svh"

package ctrl_pkg;

  //////////////////////////////
  // controller FSM states
  //////////////////////////////
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  // request from the FSM to the trap block, one per cycle
  typedef enum logic [2:0] {
    EV_NONE,
    EV_BOOT,
    EV_JUMP,
    EV_IRQ,
    EV_FLUSH
  } pc_event_e;

  //////////////////////////////
  // trap cause word
  //////////////////////////////
  // raw view goes to the CSR file, field view is what the trap block builds
  typedef union packed {
    logic [`CTRL_CAUSE_W-1:0] raw;
    struct packed {
      logic                      irq;   // set for interrupts
      logic [`CTRL_IRQ_ID_W-1:0] code;  // exception code or interrupt id
    } f;
  } trap_cause_u;

endpackage

// File: hdl/ctrl_params.svh
/*
  fixed widths and codes of the core controller
  the pc and exception vector codes must match the fetch stage decoder
  CTRL_CAUSE_W must stay equal to CTRL_IRQ_ID_W + 1 (interrupt flag + code)
*/
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// widths
`define CTRL_IRQ_ID_W   5
`define CTRL_CAUSE_W    6
`define CTRL_PC_MUX_W   3
`define CTRL_EXC_MUX_W  2

// pc selection towards the fetch stage
`define CTRL_PC_BOOT       3'b000
`define CTRL_PC_JUMP       3'b010
`define CTRL_PC_EXCEPTION  3'b100
`define CTRL_PC_ERET       3'b101
`define CTRL_PC_DBG_DPC    3'b111

// exception vector selection
`define CTRL_EXC_PC_ILLINSN  2'b00
`define CTRL_EXC_PC_ECALL    2'b01
`define CTRL_EXC_PC_IRQ      2'b11

// machine cause codes, interrupt flag clear
`define CTRL_CAUSE_ILLEGAL     6'd2
`define CTRL_CAUSE_BREAKPOINT  6'd3
`define CTRL_CAUSE_ECALL_M     6'd11

`endif
